//--- list.f
common/backendPkg.sv
hw/backendCtrl.sv
blend/colorBlend.sv
bgCache/bgBlockCache.sv
hw/gpuBackend.sv
dv/backendChecker.sv
dv/tbGpuBackend.sv

//--- dv/tbGpuBackend.sv
`timescale 1ns/100ps

module tbGpuBackend;
	import backendPkg::*;

	localparam int BlockCount = 16;
	// Longest wait for the pipeline to empty
	localparam int DrainLimit = 20;

	logic                   clk;
	logic                   i_reset;
	logic                   i_pause;
	pixelState_t            i_pixelState;
	logic [ScrXW-1:0]       i_scrX;
	logic [ScrYW-1:0]       i_scrY;
	logic [ColorW-1:0]      i_colorL, i_colorR;
	logic                   i_validL, i_validR, i_bgMskL, i_bgMskR;
	blendMode_t             i_transparency;
	logic                   i_noBlend, i_flushLastBlock, i_importBlock, i_resetPixelMask;
	logic [BlockW-1:0]      i_importData;
	logic                   o_pixelInFlight, o_writeOnNewBlock, o_stencilWrite;
	logic [BlockAdrW-1:0]   o_stencilAdr, o_loadAdr, o_saveAdr;
	logic [PairIdW-1:0]     o_stencilPair;
	logic [1:0]             o_stencilSelect, o_stencilValue;
	blockCode_t             o_saveBlockCode;
	logic [BlockW-1:0]      o_exportBlock;
	logic [PixPerBlock-1:0] o_exportMask;

	logic [15:0] lfsrState;
	int          checkCount;
	int          errorCount;
	int          timeoutErrors;

	gpuBackend gpuBackend_inst (.*);

	backendChecker backendChecker_inst (
		.i_dutInFlight      (o_pixelInFlight),
		.i_dutNewBlock      (o_writeOnNewBlock),
		.i_dutStencilWrite  (o_stencilWrite),
		.i_dutStencilAdr    (o_stencilAdr),
		.i_dutStencilPair   (o_stencilPair),
		.i_dutStencilSelect (o_stencilSelect),
		.i_dutStencilValue  (o_stencilValue),
		.i_dutLoadAdr       (o_loadAdr),
		.i_dutSaveAdr       (o_saveAdr),
		.i_dutBlockCode     (o_saveBlockCode),
		.i_dutBlock         (o_exportBlock),
		.i_dutMask          (o_exportMask),
		.o_checkCount       (checkCount),
		.o_errorCount       (errorCount),
		.*
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// Galois LFSR, one step per bit
	// ----------------------------------------
	function automatic logic [31:0] randBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			// Taps x^16 + x^14 + x^13 + x^11 + 1
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	task automatic driveIdle();
		@(posedge clk);
		i_pause <= 1'b0;
		i_validL <= 1'b0;
		i_validR <= 1'b0;
		i_pixelState <= PixIdle;
		i_flushLastBlock <= 1'b0;
	endtask

	task automatic importBlock();
		logic [BlockW-1:0] data;
		for (int i = 0; i < BlockW / 32; i++) begin
			data[i*32 +: 32] = randBits(32);
		end
		@(posedge clk);
		i_importBlock <= 1'b1;
		i_importData <= data;
		@(posedge clk);
		i_importBlock <= 1'b0;
	endtask

	task automatic clearMask();
		@(posedge clk);
		i_resetPixelMask <= 1'b1;
		@(posedge clk);
		i_resetPixelMask <= 1'b0;
	endtask

	task automatic drivePair(input logic [ScrYW-1:0] y, input logic [5:0] xHi, input int pair,
		input logic noBlend, input logic flush);
		logic paused;
		int   holds;
		@(posedge clk);
		i_scrY <= y;
		i_scrX <= {xHi, 3'(pair), 1'b0};
		i_pixelState <= (pair == 0) ? PixFirst : ((pair == PairsPerBlock - 1) ? PixLast : PixNext);
		i_colorL <= ColorW'(randBits(ColorW));
		i_colorR <= ColorW'(randBits(ColorW));
		i_validL <= 1'(randBits(1));
		i_validR <= 1'(randBits(1));
		i_bgMskL <= 1'(randBits(1));
		i_bgMskR <= 1'(randBits(1));
		i_transparency <= blendMode_t'(2'(randBits(2)));
		i_noBlend <= noBlend;
		i_flushLastBlock <= flush && (pair == PairsPerBlock - 1);
		// Pair stays on the inputs through a pause
		holds = 0;
		paused = (randBits(2) == 0);
		i_pause <= paused;
		while (paused) begin
			@(posedge clk);
			holds++;
			paused = (randBits(2) == 0) && (holds < 6);
			i_pause <= paused;
		end
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (o_pixelInFlight && cycles < DrainLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (o_pixelInFlight) begin
			timeoutErrors++;
			$display("Timeout: pixels still in flight %0d cycles after stimulus stopped", cycles);
		end
	endtask

	task automatic runBlock(input int blockNum);
		logic [ScrYW-1:0] y;
		logic [5:0]       xHi;
		logic             noBlend;
		logic             flush;
		y = ScrYW'(randBits(ScrYW));
		xHi = 6'(randBits(6));
		noBlend = (randBits(2) == 0);
		flush = (randBits(2) == 0);
		// Odd blocks start on an empty pipeline
		if (blockNum % 2 == 1) begin
			waitDrain();
		end
		// On even blocks the first pulse meets the last pair of the block before
		if (blockNum % 4 == 2) begin
			clearMask();
			importBlock();
		end else begin
			importBlock();
			clearMask();
		end
		for (int p = 0; p < PairsPerBlock; p++) begin
			drivePair(y, xHi, p, noBlend, flush);
		end
		driveIdle();
	endtask

	initial begin
		lfsrState = 16'd84;
		timeoutErrors = 0;
		i_reset = 1'b1;
		i_pause = 1'b0;
		i_pixelState = PixIdle;
		i_scrX = '0;
		i_scrY = '0;
		i_colorL = '0;
		i_colorR = '0;
		i_validL = 1'b0;
		i_validR = 1'b0;
		i_bgMskL = 1'b0;
		i_bgMskR = 1'b0;
		i_transparency = BlendAverage;
		i_noBlend = 1'b0;
		i_flushLastBlock = 1'b0;
		i_importBlock = 1'b0;
		i_importData = '0;
		i_resetPixelMask = 1'b0;
		repeat (2) @(posedge clk);
		i_reset <= 1'b0;

		for (int b = 0; b < BlockCount; b++) begin
			runBlock(b);
		end
		driveIdle();
		waitDrain();
		// Let the checker see the final block
		repeat (3) @(posedge clk);

		$display("Checks %0d, value errors %0d, timeouts %0d", checkCount, errorCount,
			timeoutErrors);
		if (errorCount == 0 && timeoutErrors == 0 && checkCount > 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- dv/backendChecker.sv
`timescale 1ns/100ps

module backendChecker (
	input  logic                               clk,
	input  logic                               i_reset,
	// Stimulus as seen by the DUT
	input  logic                               i_pause,
	input  logic [1:0]                         i_pixelState,
	input  logic [backendPkg::ScrXW-1:0]       i_scrX,
	input  logic [backendPkg::ScrYW-1:0]       i_scrY,
	input  logic [backendPkg::ColorW-1:0]      i_colorL,
	input  logic [backendPkg::ColorW-1:0]      i_colorR,
	input  logic                               i_validL,
	input  logic                               i_validR,
	input  logic                               i_bgMskL,
	input  logic                               i_bgMskR,
	input  logic [1:0]                         i_transparency,
	input  logic                               i_noBlend,
	input  logic                               i_flushLastBlock,
	input  logic                               i_importBlock,
	input  logic [backendPkg::BlockW-1:0]      i_importData,
	input  logic                               i_resetPixelMask,
	// DUT responses
	input  logic                               i_dutInFlight,
	input  logic                               i_dutNewBlock,
	input  logic                               i_dutStencilWrite,
	input  logic [backendPkg::BlockAdrW-1:0]   i_dutStencilAdr,
	input  logic [backendPkg::PairIdW-1:0]     i_dutStencilPair,
	input  logic [1:0]                         i_dutStencilSelect,
	input  logic [1:0]                         i_dutStencilValue,
	input  logic [backendPkg::BlockAdrW-1:0]   i_dutLoadAdr,
	input  logic [backendPkg::BlockAdrW-1:0]   i_dutSaveAdr,
	input  logic [1:0]                         i_dutBlockCode,
	input  logic [backendPkg::BlockW-1:0]      i_dutBlock,
	input  logic [backendPkg::PixPerBlock-1:0] i_dutMask,
	output int                                 o_checkCount,
	output int                                 o_errorCount
);
	import backendPkg::*;

	// ----------------------------------------
	// Model pipeline and block copy
	// ----------------------------------------
	// Side bits are {right, left}
	logic [1:0]             validA, validB, mskA, mskB, stateA, stateB, modeA;
	logic [ScrXW-1:0]       xA, xB;
	logic [ScrYW-1:0]       yA, yB;
	logic [ColorW-1:0]      colorAL, colorAR;
	logic                   noBlendA;
	logic [PixW-1:0]        pixBL, pixBR;
	logic [BlockW-1:0]      modelBlock;
	logic [PixPerBlock-1:0] modelMask;
	logic [BlockAdrW-1:0]   lastAdr;
	// Block data means nothing before the first import
	logic                   blockKnown;
	logic                   lastAdrKnown;

	initial begin
		o_checkCount = 0;
		o_errorCount = 0;
		blockKnown = 1'b0;
		lastAdrKnown = 1'b0;
	end

	// Semi-transparency per channel, B background and F front
	function automatic logic [ColorW-1:0] blendColor(input logic [ColorW-1:0] bg,
		input logic [ColorW-1:0] fg, input logic [1:0] mode, input logic noBlend);
		int b;
		int f;
		int r;
		logic [ColorW-1:0] res;
		if (noBlend) begin
			return fg;
		end
		for (int c = 0; c < ColorW / ChanW; c++) begin
			b = bg[c*ChanW +: ChanW];
			f = fg[c*ChanW +: ChanW];
			case (mode)
				2'd0: r = b / 2 + f / 2;
				2'd1: r = b + f;
				2'd2: r = b - f;
				default: r = b + f / 4;
			endcase
			// Clamp to the channel range
			r = (r < 0) ? 0 : ((r > 31) ? 31 : r);
			res[c*ChanW +: ChanW] = r[ChanW-1:0];
		end
		return res;
	endfunction

	task automatic checkValue(input string name, input logic [BlockW-1:0] expected,
		input logic [BlockW-1:0] actual);
		o_checkCount++;
		if (actual !== expected) begin
			o_errorCount++;
			$display("Error %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	// ----------------------------------------
	// Compare, then step the model
	// ----------------------------------------
	task automatic checkOutputs();
		logic       expWrite;
		logic [1:0] expCode;
		expWrite = !i_pause && (|validB);
		checkValue("pixelInFlight", (|validA) || (|validB), i_dutInFlight);
		// Low whenever paused
		checkValue("stencilWrite", expWrite, i_dutStencilWrite);
		if (expWrite) begin
			checkValue("stencilAdr", {yB, xB[9:4]}, i_dutStencilAdr);
			checkValue("stencilPair", xB[3:1], i_dutStencilPair);
			checkValue("stencilSelect", validB, i_dutStencilSelect);
			checkValue("stencilValue", mskB & validB, i_dutStencilValue);
		end
		if (|validB) begin
			checkValue("loadAdr", {yB, xB[9:4]}, i_dutLoadAdr);
		end
		// First block with blending off needs no load, a flush overrides the state
		if (stateB == PixFirst && i_noBlend) begin
			expCode = CodeNone;
		end else if (i_flushLastBlock) begin
			expCode = CodeFlush;
		end else begin
			expCode = stateB;
		end
		checkValue("blockCode", expCode, i_dutBlockCode);
		checkValue("writeOnNewBlock", expCode != CodeNone, i_dutNewBlock);
		if (lastAdrKnown) begin
			checkValue("saveAdr", lastAdr, i_dutSaveAdr);
		end
		if (blockKnown) begin
			checkValue("exportBlock", modelBlock, i_dutBlock);
		end
		checkValue("exportMask", modelMask, i_dutMask);
	endtask

	task automatic advanceModel();
		logic              writeNow;
		logic              fwd;
		logic [ColorW-1:0] bgL, bgR;
		logic [PixW-1:0]   newL, newR;
		writeNow = !i_pause && (|validB);
		// Background under stage A, the pending stage B pair forwarded on a match
		fwd = writeNow && ({yA, xA[9:4]} == {yB, xB[9:4]}) && (xA[3:1] == xB[3:1]);
		bgL = modelBlock[{xA[3:1], 1'b0}*PixW +: ColorW];
		bgR = modelBlock[{xA[3:1], 1'b1}*PixW +: ColorW];
		if (fwd && validB[0]) begin
			bgL = pixBL[ColorW-1:0];
		end
		if (fwd && validB[1]) begin
			bgR = pixBR[ColorW-1:0];
		end
		newL = {mskA[0], blendColor(bgL, colorAL, modeA, noBlendA)};
		newR = {mskA[1], blendColor(bgR, colorAR, modeA, noBlendA)};
		// A write beats import and mask clear
		if (writeNow) begin
			if (validB[0]) begin
				modelBlock[{xB[3:1], 1'b0}*PixW +: PixW] = pixBL;
				modelMask[{xB[3:1], 1'b0}] = 1'b1;
			end
			if (validB[1]) begin
				modelBlock[{xB[3:1], 1'b1}*PixW +: PixW] = pixBR;
				modelMask[{xB[3:1], 1'b1}] = 1'b1;
			end
			lastAdr = {yB, xB[9:4]};
			lastAdrKnown = 1'b1;
		end else begin
			if (i_importBlock) begin
				modelBlock = i_importData;
				blockKnown = 1'b1;
			end
			if (i_resetPixelMask) begin
				modelMask = '0;
			end
		end
		if (!i_pause) begin
			validB = validA;
			stateB = stateA;
			xB = xA;
			yB = yA;
			mskB = mskA;
			pixBL = newL;
			pixBR = newR;
			validA = {i_validR, i_validL};
			stateA = i_pixelState;
			xA = i_scrX;
			yA = i_scrY;
			mskA = {i_bgMskR, i_bgMskL};
			colorAL = i_colorL;
			colorAR = i_colorR;
			modeA = i_transparency;
			noBlendA = i_noBlend;
		end
	endtask

	// Inputs and outputs read here are the values before the edge
	always @(posedge clk) begin
		if (i_reset) begin
			validA = 2'b00;
			validB = 2'b00;
			stateA = PixIdle;
			stateB = PixIdle;
			modelMask = '0;
		end else begin
			checkOutputs();
			advanceModel();
		end
	end

endmodule

//--- hw/gpuBackend.sv
`timescale 1ns/100ps

module gpuBackend (
	input  logic                              clk,
	input  logic                              i_reset,
	// Freezes both stages and the write
	input  logic                              i_pause,

	// Incoming pixel pair
	input  backendPkg::pixelState_t           i_pixelState,
	input  logic [backendPkg::ScrXW-1:0]      i_scrX,
	input  logic [backendPkg::ScrYW-1:0]      i_scrY,
	input  logic [backendPkg::ColorW-1:0]     i_colorL,
	input  logic [backendPkg::ColorW-1:0]     i_colorR,
	input  logic                              i_validL,
	input  logic                              i_validR,
	input  logic                              i_bgMskL,
	input  logic                              i_bgMskR,

	// Per primitive setup
	input  backendPkg::blendMode_t            i_transparency,
	input  logic                              i_noBlend,
	input  logic                              i_flushLastBlock,

	// Block import from the memory side
	input  logic                              i_importBlock,
	input  logic [backendPkg::BlockW-1:0]     i_importData,
	input  logic                              i_resetPixelMask,

	output logic                              o_pixelInFlight,
	output logic                              o_writeOnNewBlock,

	// Stencil write back
	output logic                              o_stencilWrite,
	output logic [backendPkg::BlockAdrW-1:0]  o_stencilAdr,
	output logic [backendPkg::PairIdW-1:0]    o_stencilPair,
	output logic [1:0]                        o_stencilSelect,
	output logic [1:0]                        o_stencilValue,

	// Block load and save
	output logic [backendPkg::BlockAdrW-1:0]  o_loadAdr,
	output logic [backendPkg::BlockAdrW-1:0]  o_saveAdr,
	output backendPkg::blockCode_t            o_saveBlockCode,
	output logic [backendPkg::BlockW-1:0]     o_exportBlock,
	output logic [backendPkg::PixPerBlock-1:0] o_exportMask
);
	import backendPkg::*;

	// ----------------------------------------
	// Control to cache
	// ----------------------------------------
	logic [BlockAdrW-1:0] readAdr;
	logic [PairIdW-1:0]   readPair;
	logic                 writeEn;
	logic [PairIdW-1:0]   writePair;
	logic [1:0]           writeSel;

	// Stage A mask bits into the blenders
	logic mskL;
	logic mskR;

	// Background pair and blended pair
	logic [ColorW-1:0] bgColorL;
	logic [ColorW-1:0] bgColorR;
	logic [PixW-1:0]   pixelL;
	logic [PixW-1:0]   pixelR;

	backendCtrl backendCtrl_inst (
		.clk               (clk),
		.i_reset           (i_reset),
		.i_pause           (i_pause),
		.i_pixelState      (i_pixelState),
		.i_scrX            (i_scrX),
		.i_scrY            (i_scrY),
		.i_validL          (i_validL),
		.i_validR          (i_validR),
		.i_bgMskL          (i_bgMskL),
		.i_bgMskR          (i_bgMskR),
		.i_noBlend         (i_noBlend),
		.i_flushLastBlock  (i_flushLastBlock),
		.o_readAdr         (readAdr),
		.o_readPair        (readPair),
		.o_writeEn         (writeEn),
		.o_writePair       (writePair),
		.o_writeSel        (writeSel),
		.o_pixelInFlight   (o_pixelInFlight),
		.o_writeOnNewBlock (o_writeOnNewBlock),
		.o_stencilWrite    (o_stencilWrite),
		.o_stencilAdr      (o_stencilAdr),
		.o_stencilPair     (o_stencilPair),
		.o_stencilSelect   (o_stencilSelect),
		.o_stencilValue    (o_stencilValue),
		.o_loadAdr         (o_loadAdr),
		.o_saveAdr         (o_saveAdr),
		.o_saveBlockCode   (o_saveBlockCode),
		.o_mskL            (mskL),
		.o_mskR            (mskR)
	);

	// Left pixel of the pair
	colorBlend colorBlendL (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_pause    (i_pause),
		.i_color    (i_colorL),
		.i_bgColor  (bgColorL),
		.i_mode     (i_transparency),
		.i_noBlend  (i_noBlend),
		.i_msk      (mskL),
		.o_pixel    (pixelL)
	);

	// Right pixel of the pair
	colorBlend colorBlendR (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_pause    (i_pause),
		.i_color    (i_colorR),
		.i_bgColor  (bgColorR),
		.i_mode     (i_transparency),
		.i_noBlend  (i_noBlend),
		.i_msk      (mskR),
		.o_pixel    (pixelR)
	);

	// Write address is the stage B block, same as the stencil address
	bgBlockCache bgBlockCache_inst (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_readAdr    (readAdr),
		.i_readPair   (readPair),
		.i_writeEn    (writeEn),
		.i_writeAdr   (o_stencilAdr),
		.i_writePair  (writePair),
		.i_writeSel   (writeSel),
		.i_pixelL     (pixelL),
		.i_pixelR     (pixelR),
		.i_import     (i_importBlock),
		.i_importData (i_importData),
		.i_resetMask  (i_resetPixelMask),
		.o_bgColorL   (bgColorL),
		.o_bgColorR   (bgColorR),
		.o_block      (o_exportBlock),
		.o_mask       (o_exportMask)
	);

endmodule

//--- bgCache/bgBlockCache.sv
`timescale 1ns/100ps

module bgBlockCache (
	input  logic                                clk,
	input  logic                                i_reset,
	// Stage A pair to read
	input  logic [backendPkg::BlockAdrW-1:0]    i_readAdr,
	input  logic [backendPkg::PairIdW-1:0]      i_readPair,
	// Stage B pair to write
	input  logic                                i_writeEn,
	input  logic [backendPkg::BlockAdrW-1:0]    i_writeAdr,
	input  logic [backendPkg::PairIdW-1:0]      i_writePair,
	input  logic [1:0]                          i_writeSel,
	input  logic [backendPkg::PixW-1:0]         i_pixelL,
	input  logic [backendPkg::PixW-1:0]         i_pixelR,
	// Whole block load and mask clear
	input  logic                                i_import,
	input  logic [backendPkg::BlockW-1:0]       i_importData,
	input  logic                                i_resetMask,
	output logic [backendPkg::ColorW-1:0]       o_bgColorL,
	output logic [backendPkg::ColorW-1:0]       o_bgColorR,
	output logic [backendPkg::BlockW-1:0]       o_block,
	output logic [backendPkg::PixPerBlock-1:0]  o_mask
);
	import backendPkg::*;

	logic [BlockW-1:0]      blockData;
	// One bit per pixel, set once the pixel is written
	logic [PixPerBlock-1:0] maskBits;

	// Pixel index, left is even and right is odd
	logic [PairIdW:0] rdIdxL;
	logic [PairIdW:0] rdIdxR;
	logic [PairIdW:0] wrIdxL;
	logic [PairIdW:0] wrIdxR;

	logic [ColorW-1:0] rdColorL;
	logic [ColorW-1:0] rdColorR;
	logic              fwdHit;

	assign rdIdxL = {i_readPair, 1'b0};
	assign rdIdxR = {i_readPair, 1'b1};
	assign wrIdxL = {i_writePair, 1'b0};
	assign wrIdxR = {i_writePair, 1'b1};

	// ----------------------------------------
	// Read with forwarding
	// ----------------------------------------
	assign rdColorL = blockData[rdIdxL*PixW +: ColorW];
	assign rdColorR = blockData[rdIdxR*PixW +: ColorW];

	// Pending write to the same pair lands at this edge, use it directly
	assign fwdHit = i_writeEn && (i_readAdr == i_writeAdr) && (i_readPair == i_writePair);

	assign o_bgColorL = (fwdHit && i_writeSel[0]) ? i_pixelL[ColorW-1:0] : rdColorL;
	assign o_bgColorR = (fwdHit && i_writeSel[1]) ? i_pixelR[ColorW-1:0] : rdColorR;

	// ----------------------------------------
	// Data update
	// ----------------------------------------
	// Write has priority, import only on a free edge
	always_ff @(posedge clk) begin
		if (i_writeEn) begin
			if (i_writeSel[0]) begin
				blockData[wrIdxL*PixW +: PixW] <= i_pixelL;
			end
			if (i_writeSel[1]) begin
				blockData[wrIdxR*PixW +: PixW] <= i_pixelR;
			end
		end else if (i_import) begin
			blockData <= i_importData;
		end
	end

	// Mask update, same priority
	always_ff @(posedge clk) begin
		if (i_reset) begin
			maskBits <= '0;
		end else if (i_writeEn) begin
			if (i_writeSel[0]) begin
				maskBits[wrIdxL] <= 1'b1;
			end
			if (i_writeSel[1]) begin
				maskBits[wrIdxR] <= 1'b1;
			end
		end else if (i_resetMask) begin
			maskBits <= '0;
		end
	end

	assign o_block = blockData;
	assign o_mask  = maskBits;

	// Control never asks for a write that touches neither side
	assert property (@(posedge clk) disable iff (i_reset) i_writeEn |-> (i_writeSel != 2'b00));

endmodule

//--- blend/colorBlend.sv
`timescale 1ns/100ps

module colorBlend (
	input  logic                           clk,
	input  logic                           i_reset,
	input  logic                           i_pause,
	// Front colour, taken with the pair
	input  logic [backendPkg::ColorW-1:0]  i_color,
	// Background under the stage A pixel
	input  logic [backendPkg::ColorW-1:0]  i_bgColor,
	input  backendPkg::blendMode_t         i_mode,
	input  logic                           i_noBlend,
	input  logic                           i_msk,
	// Stage B pixel, {mask, colour}
	output logic [backendPkg::PixW-1:0]    o_pixel
);
	import backendPkg::*;

	logic [ColorW-1:0] colorA;
	blendMode_t        modeA;
	logic              noBlendA;
	logic [ColorW-1:0] blended;
	logic [PixW-1:0]   pixelB;

	// One channel, B background and F front
	function automatic logic [ChanW-1:0] blendChan(
		input logic [ChanW-1:0] bg,
		input logic [ChanW-1:0] fg,
		input blendMode_t       mode
	);
		// Two spare bits cover carry and borrow
		logic signed [ChanW+1:0] sum;
		case (mode)
			BlendAverage:    sum = $signed({2'b00, bg >> 1}) + $signed({2'b00, fg >> 1});
			BlendAdd:        sum = $signed({2'b00, bg}) + $signed({2'b00, fg});
			BlendSub:        sum = $signed({2'b00, bg}) - $signed({2'b00, fg});
			BlendAddQuarter: sum = $signed({2'b00, bg}) + $signed({2'b00, fg >> 2});
			default:         sum = $signed({2'b00, fg});
		endcase
		if (sum < 0) begin
			return '0;
		end else if (sum > ChanMax) begin
			return ChanMax[ChanW-1:0];
		end
		return sum[ChanW-1:0];
	endfunction

	// ----------------------------------------
	// Stage A, front colour and its mode
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!i_pause) begin
			colorA   <= i_color;
			modeA    <= i_mode;
			noBlendA <= i_noBlend;
		end
	end

	// r, g and b blend on their own
	always_comb begin
		for (int c = 0; c < ChanCount; c++) begin
			blended[c*ChanW +: ChanW] = blendChan(i_bgColor[c*ChanW +: ChanW],
				colorA[c*ChanW +: ChanW], modeA);
		end
		if (noBlendA) begin
			blended = colorA;
		end
	end

	// ----------------------------------------
	// Stage B, pixel waiting for the write
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!i_pause) begin
			pixelB <= {i_msk, blended};
		end
	end
	assign o_pixel = pixelB;

	// Mode comes from setup and must be driven once out of reset
	assert property (@(posedge clk) disable iff (i_reset) !$isunknown(i_mode));

endmodule

//--- hw/backendCtrl.sv
`timescale 1ns/100ps

module backendCtrl (
	input  logic                              clk,
	input  logic                              i_reset,
	input  logic                              i_pause,
	input  backendPkg::pixelState_t           i_pixelState,
	input  logic [backendPkg::ScrXW-1:0]      i_scrX,
	input  logic [backendPkg::ScrYW-1:0]      i_scrY,
	input  logic                              i_validL,
	input  logic                              i_validR,
	input  logic                              i_bgMskL,
	input  logic                              i_bgMskR,
	input  logic                              i_noBlend,
	input  logic                              i_flushLastBlock,

	// Cache read side, stage A
	output logic [backendPkg::BlockAdrW-1:0]  o_readAdr,
	output logic [backendPkg::PairIdW-1:0]    o_readPair,
	// Cache write side, stage B
	output logic                              o_writeEn,
	output logic [backendPkg::PairIdW-1:0]    o_writePair,
	output logic [1:0]                        o_writeSel,

	output logic                              o_pixelInFlight,
	output logic                              o_writeOnNewBlock,
	output logic                              o_stencilWrite,
	output logic [backendPkg::BlockAdrW-1:0]  o_stencilAdr,
	output logic [backendPkg::PairIdW-1:0]    o_stencilPair,
	output logic [1:0]                        o_stencilSelect,
	output logic [1:0]                        o_stencilValue,
	output logic [backendPkg::BlockAdrW-1:0]  o_loadAdr,
	output logic [backendPkg::BlockAdrW-1:0]  o_saveAdr,
	output backendPkg::blockCode_t            o_saveBlockCode,

	// Stage A mask bits for the blenders
	output logic                              o_mskL,
	output logic                              o_mskR
);
	import backendPkg::*;

	// ----------------------------------------
	// Stage registers
	// ----------------------------------------
	// Valid bits are {right, left}
	logic [1:0]       validA;
	logic [1:0]       validB;
	pixelState_t      stateA;
	pixelState_t      stateB;
	logic [ScrXW-1:0] xA;
	logic [ScrXW-1:0] xB;
	logic [ScrYW-1:0] yA;
	logic [ScrYW-1:0] yB;
	logic [1:0]       mskA;
	logic [1:0]       mskB;

	logic [BlockAdrW-1:0] blockAdrB;
	logic [PairIdW-1:0]   pairB;
	logic                 writeNow;
	logic [BlockAdrW-1:0] lastWriteAdr;
	blockCode_t           blockCode;

	// Control part, cleared by reset
	always_ff @(posedge clk) begin
		if (i_reset) begin
			validA <= 2'b00;
			validB <= 2'b00;
			stateA <= PixIdle;
			stateB <= PixIdle;
		end else if (!i_pause) begin
			validA <= {i_validR, i_validL};
			validB <= validA;
			stateA <= i_pixelState;
			stateB <= stateA;
		end
	end

	// Position and mask travel with the pair
	always_ff @(posedge clk) begin
		if (!i_pause) begin
			xA   <= i_scrX;
			yA   <= i_scrY;
			mskA <= {i_bgMskR, i_bgMskL};
			xB   <= xA;
			yB   <= yA;
			mskB <= mskA;
		end
	end

	// Background lookup for the pair in stage A
	assign o_readAdr  = {yA, xA[ScrXW-1:PairIdW+1]};
	assign o_readPair = xA[PairIdW:1];
	assign o_mskL     = mskA[0];
	assign o_mskR     = mskA[1];

	// ----------------------------------------
	// Stage B write back
	// ----------------------------------------
	assign blockAdrB = {yB, xB[ScrXW-1:PairIdW+1]};
	assign pairB     = xB[PairIdW:1];
	// Nothing leaves the stage while frozen
	assign writeNow  = !i_pause && (|validB);

	assign o_writeEn   = writeNow;
	assign o_writePair = pairB;
	assign o_writeSel  = validB;

	assign o_stencilWrite  = writeNow;
	assign o_stencilAdr    = blockAdrB;
	assign o_stencilPair   = pairB;
	assign o_stencilSelect = validB;
	// Sticky bit only where the pixel is really written
	assign o_stencilValue  = mskB & validB;

	// Last block that took a write is the one to save
	always_ff @(posedge clk) begin
		if (writeNow) begin
			lastWriteAdr <= blockAdrB;
		end
	end
	assign o_saveAdr = lastWriteAdr;
	assign o_loadAdr = blockAdrB;

	// ----------------------------------------
	// Block operation code
	// ----------------------------------------
	// First block needs no load when nothing blends with it
	always_comb begin
		if (stateB == PixFirst && i_noBlend) begin
			blockCode = CodeNone;
		end else begin
			blockCode = blockCode_t'(stateB | {2{i_flushLastBlock}});
		end
	end
	assign o_saveBlockCode   = blockCode;
	assign o_writeOnNewBlock = (blockCode != CodeNone);

	assign o_pixelInFlight = (|validA) || (|validB);

	// No ready signal, so the source keeps the pair on its inputs while frozen
	assert property (@(posedge clk) disable iff (i_reset)
		i_pause |=> ($stable(i_scrX) && $stable(i_scrY) && $stable(i_pixelState)));

endmodule

//--- common/backendPkg.sv
package backendPkg;

	// ----------------------------------------
	// Pixel and colour widths
	// ----------------------------------------
	localparam int ChanW = 5;
	localparam int ChanCount = 3;
	// Packed r in 4:0, g in 9:5, b in 14:10
	localparam int ColorW = ChanW * ChanCount;
	// Saturation ceiling of one channel
	localparam int ChanMax = (1 << ChanW) - 1;
	// Stored pixel, mask bit on top of the colour
	localparam int PixW = ColorW + 1;

	// ----------------------------------------
	// Block geometry
	// ----------------------------------------
	localparam int PairsPerBlock = 8;
	localparam int PixPerBlock = 2 * PairsPerBlock;
	localparam int BlockW = PixW * PixPerBlock;

	// Screen X is doubled, so bit 0 never selects a pixel
	localparam int ScrXW = 10;
	localparam int ScrYW = 9;
	// Pair inside a block comes from X bits 3..1
	localparam int PairIdW = $clog2(PairsPerBlock);
	// Y followed by X bits 9..4
	localparam int BlockAdrW = ScrYW + ScrXW - PairIdW - 1;

	// ----------------------------------------
	// Codes
	// ----------------------------------------
	typedef enum logic [1:0] {
		PixIdle  = 2'd0,
		PixFirst = 2'd1,
		PixNext  = 2'd2,
		PixLast  = 2'd3
	} pixelState_t;

	// Background B, front F
	typedef enum logic [1:0] {
		BlendAverage    = 2'd0,
		BlendAdd        = 2'd1,
		BlendSub        = 2'd2,
		BlendAddQuarter = 2'd3
	} blendMode_t;

	typedef enum logic [1:0] {
		CodeNone  = 2'd0,
		CodeFirst = 2'd1,
		CodeNext  = 2'd2,
		CodeFlush = 2'd3
	} blockCode_t;

endpackage
